// ==== logic/tron_macros.svh ====
// Light-cycle arena constants
// Arena geometry, start positions, colours, widths and APB register map
`ifndef TRON_MACROS_SVH
`define TRON_MACROS_SVH

// Coordinate widths for a 160x120 screen
`define TRON_X_W 8
`define TRON_Y_W 7

// Wall lines, a head on one of these dies
`define TRON_WALL_X_LO 8'd10
`define TRON_WALL_X_HI 8'd149
`define TRON_WALL_Y_LO 7'd17
`define TRON_WALL_Y_HI 7'd108

// Playing field swept black between rounds
`define TRON_FIELD_X_MIN 8'd11
`define TRON_FIELD_X_MAX 8'd148
`define TRON_FIELD_Y_MIN 7'd18
`define TRON_FIELD_Y_MAX 7'd107

// Start positions, both heading up
`define TRON_P1_START_X 8'd25
`define TRON_P2_START_X 8'd135
`define TRON_START_Y    7'd100

// 3-bit RGB colours
`define TRON_COLOUR_BLACK 3'd0
`define TRON_COLOUR_P1    3'd1
`define TRON_COLOUR_P2    3'd4

// Step period in clocks
`define TRON_STEP_W     16
`define TRON_STEP_RESET 16'd1000
`define TRON_STEP_MIN   16'd4

// APB bus widths and register offsets
`define TRON_APB_ADDR_W 4
`define TRON_APB_DATA_W 32
`define TRON_ADDR_CTRL   4'h0
`define TRON_ADDR_STEP   4'h4
`define TRON_ADDR_STATUS 4'h8
`define TRON_ADDR_SCORE  4'hC

`endif

// ==== logic/tron_pkg.sv ====
// Light-cycle arena types
// Coordinates, colours, headings, buttons, score digits and step period
`include "tron_macros.svh"

package tron_pkg;

    typedef logic [`TRON_X_W-1:0] coord_x_t;
    typedef logic [`TRON_Y_W-1:0] coord_y_t;
    typedef logic [2:0] colour_t;

    // Heading, up is towards smaller y
    typedef enum logic [1:0] {
        dir_up,
        dir_right,
        dir_down,
        dir_left
    } dir_t;

    // Buttons as {left, down, up, right}
    typedef logic [3:0] steer_t;

    // Accepted one-hot button codes
    localparam steer_t steer_right = 4'b0001;
    localparam steer_t steer_up    = 4'b0010;
    localparam steer_t steer_down  = 4'b0100;
    localparam steer_t steer_left  = 4'b1000;

    typedef logic [3:0] bcd_t;
    typedef logic [`TRON_STEP_W-1:0] step_t;

endpackage

// ==== logic/light_cycle.sv ====
// Light cycle for one player
// Direction machine taking quarter turns only, and the head position register
`timescale 1ns/1ns

module light_cycle #(
    parameter tron_pkg::coord_x_t START_X = '0,
    parameter tron_pkg::coord_y_t START_Y = '0
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               restart,
    input  logic               step,
    input  tron_pkg::steer_t   buttons,
    output tron_pkg::coord_x_t head_x,
    output tron_pkg::coord_y_t head_y
);
    import tron_pkg::*;

    dir_t dir;
    dir_t dir_next;

    // Turn table
    // Only an exact one-hot code at right angles to the heading turns
    always_comb begin
        dir_next = dir;
        case (dir)
            dir_up, dir_down: begin
                if (buttons == steer_right) begin
                    dir_next = dir_right;
                end else if (buttons == steer_left) begin
                    dir_next = dir_left;
                end
            end
            dir_right, dir_left: begin
                if (buttons == steer_up) begin
                    dir_next = dir_up;
                end else if (buttons == steer_down) begin
                    dir_next = dir_down;
                end
            end
            default: dir_next = dir_up;
        endcase
    end

    // Buttons sampled every clock, head moves only on step
    always_ff @(posedge clk) begin
        if (!resetn || restart) begin
            // Back to start, heading up
            dir    <= dir_up;
            head_x <= START_X;
            head_y <= START_Y;
        end else begin
            dir <= dir_next;
            if (step) begin
                // Move with the heading held before this edge
                case (dir)
                    dir_up:    head_y <= head_y - coord_y_t'(1);
                    dir_down:  head_y <= head_y + coord_y_t'(1);
                    dir_right: head_x <= head_x + coord_x_t'(1);
                    dir_left:  head_x <= head_x - coord_x_t'(1);
                    default:   head_y <= head_y;
                endcase
            end
        end
    end

    // Outside a restart the heading only ever changes axis, never reverses
    a_quarter_turn: assert property (@(posedge clk) disable iff (!resetn)
        (!$past(restart) && (dir != $past(dir))) |-> (dir[0] != $past(dir[0])));

endmodule

// ==== logic/arena_referee.sv ====
// Arena referee
// Step timer, judging of both heads, black field sweep and the pixel plot port
`timescale 1ns/1ns

`include "tron_macros.svh"

module arena_referee (
    input  logic               clk,
    input  logic               resetn,
    input  logic               run,
    input  tron_pkg::step_t    step_period,
    input  tron_pkg::coord_x_t p1_x,
    input  tron_pkg::coord_x_t p2_x,
    input  tron_pkg::coord_y_t p1_y,
    input  tron_pkg::coord_y_t p2_y,
    output logic               step,
    output logic               restart,
    output logic               clearing,
    output logic               p1_died,
    output logic               p2_died,
    output logic               plot,
    output tron_pkg::coord_x_t plot_x,
    output tron_pkg::coord_y_t plot_y,
    output tron_pkg::colour_t  plot_colour
);
    import tron_pkg::*;

    typedef enum logic [1:0] {
        ph_sweep,
        ph_idle,
        ph_judge_p1,
        ph_judge_p2
    } phase_t;

    phase_t   phase;
    step_t    step_cnt;
    coord_x_t sweep_x;
    coord_y_t sweep_y;
    logic     counting;
    logic     p1_hit;
    logic     p2_hit;

    // Head on a wall line or on the other head
    function automatic logic head_hit(input coord_x_t hx, input coord_y_t hy,
                                      input coord_x_t ox, input coord_y_t oy);
        return (hx == `TRON_WALL_X_LO) || (hx == `TRON_WALL_X_HI) ||
               (hy == `TRON_WALL_Y_LO) || (hy == `TRON_WALL_Y_HI) ||
               ((hx == ox) && (hy == oy));
    endfunction

    // Cycles hold their start while the field is cleared
    assign restart = clearing;

    // Timer frozen while a sweep is running or about to end
    assign counting = run && !clearing && (phase != ph_sweep);

    assign p1_hit = head_hit(p1_x, p1_y, p2_x, p2_y);
    assign p2_hit = head_hit(p2_x, p2_y, p1_x, p1_y);

    // Step timer, one pulse every step_period clocks
    always_ff @(posedge clk) begin
        if (!resetn || !counting) begin
            step_cnt <= '0;
            step     <= 1'b0;
        end else if (step_cnt >= step_period - step_t'(1)) begin
            step_cnt <= '0;
            step     <= 1'b1;
        end else begin
            step_cnt <= step_cnt + step_t'(1);
            step     <= 1'b0;
        end
    end

    // Phase sequence
    // Sweep after reset or a death, then wait for step, judge p1, judge p2
    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase    <= ph_sweep;
            clearing <= 1'b1;
            sweep_x  <= `TRON_FIELD_X_MIN;
            sweep_y  <= `TRON_FIELD_Y_MIN;
            p1_died  <= 1'b0;
            p2_died  <= 1'b0;
            plot     <= 1'b0;
        end else begin
            // clearing trails the phase so it falls after the last pixel
            clearing <= (phase == ph_sweep);
            p1_died  <= 1'b0;
            p2_died  <= 1'b0;
            plot     <= 1'b0;
            case (phase)
                ph_sweep: begin
                    plot <= 1'b1;
                    // y inner loop, x outer loop
                    if (sweep_y == `TRON_FIELD_Y_MAX) begin
                        sweep_y <= `TRON_FIELD_Y_MIN;
                        if (sweep_x == `TRON_FIELD_X_MAX) begin
                            sweep_x <= `TRON_FIELD_X_MIN;
                            phase   <= ph_idle;
                        end else begin
                            sweep_x <= sweep_x + coord_x_t'(1);
                        end
                    end else begin
                        sweep_y <= sweep_y + coord_y_t'(1);
                    end
                end
                ph_idle: begin
                    // Heads move on the step edge, judged in the next cycle
                    if (step) begin
                        phase <= ph_judge_p1;
                    end
                end
                ph_judge_p1: begin
                    if (p1_hit) begin
                        // p2 is not judged this step
                        p1_died <= 1'b1;
                        phase   <= ph_sweep;
                    end else begin
                        plot  <= 1'b1;
                        phase <= ph_judge_p2;
                    end
                end
                ph_judge_p2: begin
                    if (p2_hit) begin
                        p2_died <= 1'b1;
                        phase   <= ph_sweep;
                    end else begin
                        plot  <= 1'b1;
                        phase <= ph_idle;
                    end
                end
                default: phase <= ph_sweep;
            endcase
        end
    end

    // Pixel payload, qualified by plot
    always_ff @(posedge clk) begin
        case (phase)
            ph_sweep: begin
                plot_x      <= sweep_x;
                plot_y      <= sweep_y;
                plot_colour <= `TRON_COLOUR_BLACK;
            end
            ph_judge_p1: begin
                plot_x      <= p1_x;
                plot_y      <= p1_y;
                plot_colour <= `TRON_COLOUR_P1;
            end
            ph_judge_p2: begin
                plot_x      <= p2_x;
                plot_y      <= p2_y;
                plot_colour <= `TRON_COLOUR_P2;
            end
            default: plot_colour <= plot_colour;
        endcase
    end

    // No pixel lands on or outside a wall, whichever cycle produced the head
    a_plot_in_field: assert property (@(posedge clk) disable iff (!resetn)
        plot |-> (plot_x > `TRON_WALL_X_LO) && (plot_x < `TRON_WALL_X_HI) &&
                 (plot_y > `TRON_WALL_Y_LO) && (plot_y < `TRON_WALL_Y_HI));

endmodule

// ==== logic/tron_apb_regs.sv ====
// APB register block for the arena
// Run enable, step period, sticky death status and BCD scores
`timescale 1ns/1ns

`include "tron_macros.svh"

module tron_apb_regs (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`TRON_APB_ADDR_W-1:0] paddr,
    input  logic [`TRON_APB_DATA_W-1:0] pwdata,
    output logic [`TRON_APB_DATA_W-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic                        p1_died,
    input  logic                        p2_died,
    input  logic                        clearing,
    output logic                        run,
    output tron_pkg::step_t             step_period
);
    import tron_pkg::*;

    logic  access;
    logic  wr_en;
    logic  mapped;
    logic  clearing_q;
    logic  p1_dead;
    logic  p2_dead;
    step_t step_wdata;
    bcd_t  p1_ones;
    bcd_t  p1_tens;
    bcd_t  p2_ones;
    bcd_t  p2_tens;

    // Two-digit BCD increment, 99 wraps to 00
    function automatic logic [7:0] bcd_inc(input bcd_t tens, input bcd_t ones);
        if (ones != 4'd9) begin
            return {tens, bcd_t'(ones + 4'd1)};
        end else if (tens != 4'd9) begin
            return {bcd_t'(tens + 4'd1), 4'd0};
        end
        return 8'h00;
    endfunction

    // Zero wait states
    assign pready  = 1'b1;
    assign access  = psel && penable;
    assign wr_en   = access && pwrite;
    assign mapped  = paddr inside {`TRON_ADDR_CTRL, `TRON_ADDR_STEP,
                                   `TRON_ADDR_STATUS, `TRON_ADDR_SCORE};
    assign pslverr = access && !mapped;

    // Step period saturates high and clamps to the minimum low
    always_comb begin
        if (|pwdata[`TRON_APB_DATA_W-1:`TRON_STEP_W]) begin
            step_wdata = '1;
        end else if (pwdata[`TRON_STEP_W-1:0] < `TRON_STEP_MIN) begin
            step_wdata = `TRON_STEP_MIN;
        end else begin
            step_wdata = pwdata[`TRON_STEP_W-1:0];
        end
    end

    // Control registers
    always_ff @(posedge clk) begin
        if (!resetn) begin
            run         <= 1'b0;
            step_period <= `TRON_STEP_RESET;
        end else if (wr_en) begin
            if (paddr == `TRON_ADDR_CTRL) begin
                run <= pwdata[0];
            end
            if (paddr == `TRON_ADDR_STEP) begin
                step_period <= step_wdata;
            end
        end
    end

    // Dead flags held until the sweep finishes and the next round starts
    always_ff @(posedge clk) begin
        if (!resetn) begin
            clearing_q <= 1'b0;
            p1_dead    <= 1'b0;
            p2_dead    <= 1'b0;
        end else begin
            clearing_q <= clearing;
            if (p1_died) begin
                p1_dead <= 1'b1;
            end else if (clearing_q && !clearing) begin
                p1_dead <= 1'b0;
            end
            if (p2_died) begin
                p2_dead <= 1'b1;
            end else if (clearing_q && !clearing) begin
                p2_dead <= 1'b0;
            end
        end
    end

    // Scores, a death is a point for the opponent
    always_ff @(posedge clk) begin
        if (!resetn || (wr_en && (paddr == `TRON_ADDR_SCORE))) begin
            p1_ones <= '0;
            p1_tens <= '0;
            p2_ones <= '0;
            p2_tens <= '0;
        end else begin
            if (p1_died) begin
                {p2_tens, p2_ones} <= bcd_inc(p2_tens, p2_ones);
            end
            if (p2_died) begin
                {p1_tens, p1_ones} <= bcd_inc(p1_tens, p1_ones);
            end
        end
    end

    // Read mux, valid whenever the address is stable
    always_comb begin
        case (paddr)
            `TRON_ADDR_CTRL:   prdata = {31'd0, run};
            `TRON_ADDR_STEP:   prdata = {16'd0, step_period};
            `TRON_ADDR_STATUS: prdata = {29'd0, clearing, p2_dead, p1_dead};
            `TRON_ADDR_SCORE:  prdata = {16'd0, p2_tens, p2_ones, p1_tens, p1_ones};
            default:           prdata = '0;
        endcase
    end

    // Access phase never without select
    a_penable_psel: assert property (@(posedge clk) disable iff (!resetn)
        penable |-> psel);

    // Setup phase always followed by access phase
    a_setup_access: assert property (@(posedge clk) disable iff (!resetn)
        (psel && !penable) |=> (psel && penable));

endmodule

// ==== logic/tron_top.sv ====
// Light-cycle arena top level
// Two cycles, the referee and the APB register block
`timescale 1ns/1ns

`include "tron_macros.svh"

module tron_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`TRON_APB_ADDR_W-1:0] paddr,
    input  logic [`TRON_APB_DATA_W-1:0] pwdata,
    output logic [`TRON_APB_DATA_W-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  tron_pkg::steer_t            p1_buttons,
    input  tron_pkg::steer_t            p2_buttons,
    output logic                        plot,
    output tron_pkg::coord_x_t          plot_x,
    output tron_pkg::coord_y_t          plot_y,
    output tron_pkg::colour_t           plot_colour
);
    import tron_pkg::*;

    coord_x_t p1_x;
    coord_x_t p2_x;
    coord_y_t p1_y;
    coord_y_t p2_y;
    logic     step;
    logic     restart;
    logic     clearing;
    logic     p1_died;
    logic     p2_died;
    logic     run;
    step_t    step_period;

    // Player 1, blue, starts on the left
    light_cycle #(
        .START_X (`TRON_P1_START_X),
        .START_Y (`TRON_START_Y)
    ) u_cycle_p1 (
        .clk     (clk),
        .resetn  (resetn),
        .restart (restart),
        .step    (step),
        .buttons (p1_buttons),
        .head_x  (p1_x),
        .head_y  (p1_y)
    );

    // Player 2, red, starts on the right
    light_cycle #(
        .START_X (`TRON_P2_START_X),
        .START_Y (`TRON_START_Y)
    ) u_cycle_p2 (
        .clk     (clk),
        .resetn  (resetn),
        .restart (restart),
        .step    (step),
        .buttons (p2_buttons),
        .head_x  (p2_x),
        .head_y  (p2_y)
    );

    arena_referee u_referee (
        .clk         (clk),
        .resetn      (resetn),
        .run         (run),
        .step_period (step_period),
        .p1_x        (p1_x),
        .p2_x        (p2_x),
        .p1_y        (p1_y),
        .p2_y        (p2_y),
        .step        (step),
        .restart     (restart),
        .clearing    (clearing),
        .p1_died     (p1_died),
        .p2_died     (p2_died),
        .plot        (plot),
        .plot_x      (plot_x),
        .plot_y      (plot_y),
        .plot_colour (plot_colour)
    );

    tron_apb_regs u_regs (
        .clk         (clk),
        .resetn      (resetn),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .p1_died     (p1_died),
        .p2_died     (p2_died),
        .clearing    (clearing),
        .run         (run),
        .step_period (step_period)
    );

endmodule

// ==== bench/tron_tb.sv ====
// Testbench for the light-cycle arena
// Drives APB and buttons, watches the plot port and checks against a step model
`timescale 1ns/1ns

`include "tron_macros.svh"

module tron_tb;

    localparam int DIR_UP    = 0;
    localparam int DIR_RIGHT = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_LEFT  = 3;
    // Field is 138 columns by 90 rows
    localparam int SWEEP_PIXELS =
        (int'(`TRON_FIELD_X_MAX) - int'(`TRON_FIELD_X_MIN) + 1) *
        (int'(`TRON_FIELD_Y_MAX) - int'(`TRON_FIELD_Y_MIN) + 1);

    logic                        clk;
    logic                        resetn;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`TRON_APB_ADDR_W-1:0] paddr;
    logic [`TRON_APB_DATA_W-1:0] pwdata;
    logic [`TRON_APB_DATA_W-1:0] prdata;
    logic                        pready;
    logic                        pslverr;
    logic [3:0]                  p1_buttons;
    logic [3:0]                  p2_buttons;
    logic                        plot;
    logic [`TRON_X_W-1:0]        plot_x;
    logic [`TRON_Y_W-1:0]        plot_y;
    logic [2:0]                  plot_colour;

    // Plot monitor state
    int                   black_count = 0;
    int                   outside_count = 0;
    logic                 prev_black = 1'b0;
    logic [`TRON_X_W-1:0] first_x;
    logic [`TRON_Y_W-1:0] first_y;
    logic [`TRON_X_W-1:0] last_x;
    logic [`TRON_Y_W-1:0] last_y;
    logic [17:0]          game_q[$];

    // Bookkeeping and model scores
    int          checks = 0;
    int          errors = 0;
    int          score_p1 = 0;
    int          score_p2 = 0;
    logic [31:0] rng_state = 32'ha97f_e2bc;
    logic        step_err;

    tron_top u_dut (
        .clk         (clk),
        .resetn      (resetn),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .p1_buttons  (p1_buttons),
        .p2_buttons  (p2_buttons),
        .plot        (plot),
        .plot_x      (plot_x),
        .plot_y      (plot_y),
        .plot_colour (plot_colour)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Pre-edge values sampled, black pixels counted, game pixels queued
    always @(posedge clk) begin
        if (resetn && plot) begin
            if (plot_colour == `TRON_COLOUR_BLACK) begin
                // First black pixel after a gap opens a sweep
                if (!prev_black) begin
                    first_x = plot_x;
                    first_y = plot_y;
                end
                black_count++;
                last_x = plot_x;
                last_y = plot_y;
                if ((plot_x < `TRON_FIELD_X_MIN) || (plot_x > `TRON_FIELD_X_MAX) ||
                    (plot_y < `TRON_FIELD_Y_MIN) || (plot_y > `TRON_FIELD_Y_MAX)) begin
                    outside_count++;
                end
                prev_black = 1'b1;
            end else begin
                game_q.push_back({plot_colour, plot_x, plot_y});
                prev_black = 1'b0;
            end
        end else begin
            prev_black = 1'b0;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic is_one_hot(input logic [3:0] b);
        return (b == 4'b0001) || (b == 4'b0010) || (b == 4'b0100) || (b == 4'b1000);
    endfunction

    // Quarter turns only, buttons are {left, down, up, right}
    function automatic int turn_dir(input int d, input logic [3:0] b);
        if ((d == DIR_UP || d == DIR_DOWN) && (b == 4'b0001)) return DIR_RIGHT;
        if ((d == DIR_UP || d == DIR_DOWN) && (b == 4'b1000)) return DIR_LEFT;
        if ((d == DIR_RIGHT || d == DIR_LEFT) && (b == 4'b0010)) return DIR_UP;
        if ((d == DIR_RIGHT || d == DIR_LEFT) && (b == 4'b0100)) return DIR_DOWN;
        return d;
    endfunction

    function automatic int next_x(input int x, input int d);
        if (d == DIR_RIGHT) return x + 1;
        if (d == DIR_LEFT) return x - 1;
        return x;
    endfunction

    // Up is towards smaller y
    function automatic int next_y(input int y, input int d);
        if (d == DIR_DOWN) return y + 1;
        if (d == DIR_UP) return y - 1;
        return y;
    endfunction

    function automatic logic on_wall(input int x, input int y);
        return (x == int'(`TRON_WALL_X_LO)) || (x == int'(`TRON_WALL_X_HI)) ||
               (y == int'(`TRON_WALL_Y_LO)) || (y == int'(`TRON_WALL_Y_HI));
    endfunction

    // SCORE layout p2 tens, p2 ones, p1 tens, p1 ones
    function automatic logic [31:0] score_word();
        return 32'({4'(score_p2 / 10), 4'(score_p2 % 10),
                    4'(score_p1 / 10), 4'(score_p1 % 10)});
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // Setup phase, access phase, write lands on the edge ending it
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        err = pslverr;
        // Zero wait states, ready in every access phase
        check_value("apb write pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;
        err  = pslverr;
        check_value("apb read pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_black(input int target, input int limit, input string what);
        int n;
        n = 0;
        while ((black_count < target) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        if (black_count < target) begin
            $display("Timeout in %s: only %0d of %0d black pixels after %0d cycles",
                     what, black_count, target, limit);
            errors++;
            finish_run();
        end
    endtask

    // Round over once STATUS shows no sweep and no dead flag
    task automatic wait_round_idle(input string what);
        logic [31:0] rd;
        logic        err;
        int          n;
        n  = 0;
        rd = 32'hffff_ffff;
        while ((rd != 32'd0) && (n < 20)) begin
            apb_read(`TRON_ADDR_STATUS, rd, err);
            n++;
        end
        if (rd != 32'd0) begin
            $display("Timeout in %s: STATUS still 0x%0h after %0d reads", what, rd, n);
            errors++;
            finish_run();
        end
    endtask

    task automatic check_sweep(input string name, input int base);
        wait_black(base + SWEEP_PIXELS, SWEEP_PIXELS + 1000, name);
        wait_round_idle(name);
        check_value({name, " pixel count"}, SWEEP_PIXELS, black_count - base);
        check_value({name, " first pixel"},
                    32'({`TRON_FIELD_X_MIN, `TRON_FIELD_Y_MIN}), 32'({first_x, first_y}));
        check_value({name, " last pixel"},
                    32'({`TRON_FIELD_X_MAX, `TRON_FIELD_Y_MAX}), 32'({last_x, last_y}));
        check_value({name, " pixels outside field"}, 32'd0, outside_count);
    endtask

    // One round from start to death, predicted in full before run is set
    task automatic play_round(input string name, input logic [3:0] b1, input logic [3:0] b2);
        int          x1;
        int          y1;
        int          d1;
        int          x2;
        int          y2;
        int          d2;
        int          steps;
        int          loser;
        int          base;
        logic [31:0] rd;
        logic        err;
        logic [17:0] exp_q[$];
        // Buttons held, so sampled repeatedly before the first step
        d1    = turn_dir(turn_dir(DIR_UP, b1), b1);
        d2    = turn_dir(turn_dir(DIR_UP, b2), b2);
        x1    = int'(`TRON_P1_START_X);
        y1    = int'(`TRON_START_Y);
        x2    = int'(`TRON_P2_START_X);
        y2    = int'(`TRON_START_Y);
        loser = 0;
        steps = 0;
        while ((loser == 0) && (steps < 1000)) begin
            x1 = next_x(x1, d1);
            y1 = next_y(y1, d1);
            x2 = next_x(x2, d2);
            y2 = next_y(y2, d2);
            steps++;
            // p1 judged first, p2 only if p1 survives
            if (on_wall(x1, y1) || ((x1 == x2) && (y1 == y2))) begin
                loser = 1;
            end else begin
                exp_q.push_back({`TRON_COLOUR_P1, 8'(x1), 7'(y1)});
                if (on_wall(x2, y2) || ((x1 == x2) && (y1 == y2))) begin
                    loser = 2;
                end else begin
                    exp_q.push_back({`TRON_COLOUR_P2, 8'(x2), 7'(y2)});
                end
            end
        end
        if (loser == 1) begin
            score_p2 = (score_p2 + 1) % 100;
        end else if (loser == 2) begin
            score_p1 = (score_p1 + 1) % 100;
        end

        @(negedge clk);
        p1_buttons = b1;
        p2_buttons = b2;
        game_q.delete();
        base = black_count;
        apb_write(`TRON_ADDR_CTRL, 32'd1, err);
        // First black pixel marks the death
        wait_black(base + 1, steps * 8 + 100, {name, " death"});
        // Restart is high now, both cycles stay at the start heading up
        @(negedge clk);
        p1_buttons = 4'b0000;
        p2_buttons = 4'b0000;
        apb_write(`TRON_ADDR_CTRL, 32'd0, err);
        apb_read(`TRON_ADDR_STATUS, rd, err);
        check_value({name, " status"}, {29'd0, 1'b1, loser == 2, loser == 1}, rd);
        check_sweep({name, " sweep"}, base);

        check_value({name, " pixel total"}, exp_q.size(), game_q.size());
        for (int i = 0; (i < exp_q.size()) && (i < game_q.size()); i++) begin
            check_value($sformatf("%s pixel %0d", name, i), 32'(exp_q[i]), 32'(game_q[i]));
        end
        apb_read(`TRON_ADDR_SCORE, rd, err);
        check_value({name, " score"}, score_word(), rd);
    endtask

    // Runs during the reset sweep
    task automatic test_registers();
        logic [31:0] rd;
        logic        err;
        apb_read(`TRON_ADDR_CTRL, rd, err);
        check_value("reset ctrl", 32'd0, rd);
        check_value("reset ctrl pslverr", 32'd0, 32'(err));
        apb_read(`TRON_ADDR_STEP, rd, err);
        check_value("reset step", 32'd1000, rd);
        apb_read(`TRON_ADDR_SCORE, rd, err);
        check_value("reset score", 32'd0, rd);
        apb_read(`TRON_ADDR_STATUS, rd, err);
        check_value("status while clearing", 32'd4, rd);
        // Below the minimum stored as 4
        apb_write(`TRON_ADDR_STEP, 32'd2, err);
        apb_read(`TRON_ADDR_STEP, rd, err);
        check_value("step clamp", 32'd4, rd);
        apb_write(`TRON_ADDR_STEP, 32'd20, err);
        apb_read(`TRON_ADDR_STEP, rd, err);
        check_value("step write", 32'd20, rd);
        apb_read(4'h2, rd, err);
        check_value("unmapped read pslverr", 32'd1, 32'(err));
        apb_write(4'h6, 32'd1, err);
        check_value("unmapped write pslverr", 32'd1, 32'(err));
    endtask

    task automatic test_steering();
        logic [3:0] code;
        int         n;
        code = 4'b0001;
        n    = 0;
        while (is_one_hot(code) && (n < 64)) begin
            rng_state = xorshift32(rng_state);
            code      = rng_state[3:0];
            n++;
        end
        $display("Steering with p2 code %b", code);
        play_round("steering", 4'b0001, code);
    endtask

    task automatic test_score_carry();
        logic [31:0] rd;
        logic        err;
        repeat (10) begin
            play_round("score round", 4'b0000, 4'b0000);
        end
        apb_read(`TRON_ADDR_SCORE, rd, err);
        check_value("score carry", score_word(), rd);
        // Any write clears both players
        apb_write(`TRON_ADDR_SCORE, 32'h0000_1234, err);
        score_p1 = 0;
        score_p2 = 0;
        apb_read(`TRON_ADDR_SCORE, rd, err);
        check_value("score clear", score_word(), rd);
    endtask

    initial begin
        resetn     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        p1_buttons = 4'b0000;
        p2_buttons = 4'b0000;
        repeat (2) @(negedge clk);
        resetn = 1'b1;

        test_registers();
        check_sweep("reset sweep", 0);
        apb_write(`TRON_ADDR_STEP, 32'd4, step_err);
        check_value("step 4 write pslverr", 32'd0, 32'(step_err));
        play_round("wall run", 4'b0000, 4'b0000);
        test_steering();
        // Heads meet at (80,100) on step 55
        play_round("head on", 4'b0001, 4'b1000);
        test_score_carry();
        finish_run();
    end

endmodule

// ==== tb.f ====
+incdir+logic
logic/tron_pkg.sv
logic/light_cycle.sv
logic/arena_referee.sv
logic/tron_apb_regs.sv
logic/tron_top.sv
bench/tron_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arena testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tron_tb -o tron_sim
./obj_dir/tron_sim > sim.log
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "Testbench reported errors"
    exit 1
fi
echo "Testbench finished cleanly"
